// ==== common/beat_push_if.sv ====
`timescale 1ns/100ps

interface beat_push_if
   import mem_pkg::*;
();

   logic beat_valid;
   mask_beat_u beat;
   logic frame_start;
   logic room;

   // Fetch side.
   modport producer (
      output beat_valid,
      output beat,
      output frame_start,
      input room
   );

   // Buffer side.
   modport consumer (
      input beat_valid,
      input beat,
      input frame_start,
      output room
   );

endinterface

// ==== common/mem_pkg.sv ====
package mem_pkg;

   localparam int BEAT_BYTES = 8;
   localparam int BEAT_W = BEAT_BYTES * 8;

   // One memory beat seen either as the bus word or as eight mask bytes.
   // Byte 0 sits in the low bits and belongs to the lowest address.
   typedef union packed {
      logic [BEAT_W-1:0] raw;
      logic [BEAT_BYTES-1:0][7:0] bytes;
   } mask_beat_u;

endpackage

// ==== common/overlay_consts.svh ====
`ifndef OVERLAY_CONSTS_SVH
`define OVERLAY_CONSTS_SVH

// Frame size in pixels.
`define OVL_H_WIDTH 32
`define OVL_V_HEIGHT 4

// Byte address of the first mask byte.
`define OVL_BASE 32'h2100_0000

// Beats per read burst.
`define OVL_BURST_LEN 4

// Mask buffer depth in beats.
`define OVL_FIFO_BEATS 8

// Overlay stays enabled this many cycles after a mode change.
`define OVL_MAX_CNT 32'd400

`endif

// ==== common/video_pkg.sv ====
package video_pkg;

   localparam int CH_W = 8;
   localparam int NUM_CH = 3;
   localparam int PIX_W = CH_W * NUM_CH;

   localparam logic [CH_W-1:0] CH_MID = 1 << (CH_W - 1);

   // Fold one channel about mid-scale.
   function automatic logic [CH_W-1:0] fold_channel(input logic [CH_W-1:0] ch);
      logic [CH_W-1:0] res;
      if (ch >= CH_MID) begin
         res = ch - CH_MID;
      end else begin
         res = (CH_MID - 1'b1) - ch;
      end
      return res;
   endfunction

endpackage

// ==== hw/mask_fifo.sv ====
`timescale 1ns/100ps

`include "overlay_consts.svh"

module mask_fifo
   import mem_pkg::*;
(
   input logic vin_clk_i,
   input logic rst_ni,
   beat_push_if.consumer push_i,
   input logic pop_i,
   output logic [7:0] mask_o
);

   localparam int DEPTH = `OVL_FIFO_BEATS;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam int IDX_W = $clog2(BEAT_BYTES);

   mask_beat_u mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic [IDX_W-1:0] byte_idx_q;
   logic [7:0] mask_q;
   logic empty;
   logic do_pop;
   logic retire;

   assign empty = (count_q == '0);
   assign do_pop = pop_i && !empty;
   assign retire = do_pop && (byte_idx_q == IDX_W'(BEAT_BYTES - 1));

   always_ff @(posedge vin_clk_i) begin
      if (push_i.beat_valid) begin
         mem[wr_ptr_q] <= push_i.beat;
      end
   end

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
         byte_idx_q <= '0;
         mask_q <= '0;
      end else if (push_i.frame_start) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
         byte_idx_q <= '0;
         mask_q <= '0;
      end else begin
         if (push_i.beat_valid) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (retire) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push_i.beat_valid && !retire) begin
            count_q <= count_q + 1'b1;
         end else if (retire && !push_i.beat_valid) begin
            count_q <= count_q - 1'b1;
         end
         if (do_pop) begin
            byte_idx_q <= byte_idx_q + 1'b1;
         end
         // Empty buffer gives a zero byte, so the pixel passes.
         mask_q <= do_pop ? mem[rd_ptr_q].bytes[byte_idx_q] : 8'h00;
      end
   end

   assign push_i.room = (CNT_W'(DEPTH) - count_q) >= CNT_W'(`OVL_BURST_LEN);
   assign mask_o = mask_q;

endmodule

// ==== hw/mask_timer.sv ====
`timescale 1ns/100ps

`include "overlay_consts.svh"

module mask_timer (
   input logic vin_clk_i,
   input logic rst_ni,
   input logic [2:0] mode_i,
   output logic [2:0] mode_o,
   output logic en_o
);

   logic [31:0] cnt_q;
   logic [2:0] mode_q;
   logic en_q;

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cnt_q <= '0;
         mode_q <= '0;
         en_q <= 1'b1;
      end else if (mode_i != mode_q) begin
         cnt_q <= '0;
         mode_q <= mode_i;
         en_q <= 1'b1;
      end else if (cnt_q < `OVL_MAX_CNT - 32'd1) begin
         cnt_q <= cnt_q + 32'd1;
         en_q <= 1'b1;
      end else begin
         en_q <= 1'b0;
      end
   end

   assign mode_o = mode_q;
   assign en_o = en_q;

endmodule

// ==== hw/overlay_ctrl.sv ====
`timescale 1ns/100ps

`include "overlay_consts.svh"

module overlay_ctrl
   import mem_pkg::*;
(
   input logic vin_clk_i,
   input logic rst_ni,
   input logic vin_vs_i,
   beat_push_if.producer push_o,
   output logic [31:0] araddr_o,
   output logic [3:0] arlen_o,
   output logic arvalid_o,
   input logic arready_i,
   input logic [BEAT_W-1:0] rdata_i,
   input logic rvalid_i,
   output logic rready_o,
   input logic rlast_i
);

   localparam logic [31:0] BURST_BYTES = `OVL_BURST_LEN * BEAT_BYTES;
   localparam logic [31:0] FRAME_BYTES = `OVL_H_WIDTH * `OVL_V_HEIGHT;

   typedef enum logic [1:0] {IDLE, ADDR, DATA, DONE} state_e;

   state_e state_q;
   logic vs_q;
   logic vs_rise;
   logic frame_start_q;
   logic drop_q;
   logic burst_end;
   logic [31:0] ar_addr_q;
   logic [31:0] next_addr_q;
   logic [31:0] req_left_q;

   assign vs_rise = vin_vs_i & ~vs_q;
   assign burst_end = (state_q == DATA) && rvalid_i && rlast_i;

   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= IDLE;
         vs_q <= 1'b0;
         frame_start_q <= 1'b0;
         drop_q <= 1'b0;
         ar_addr_q <= '0;
         next_addr_q <= `OVL_BASE;
         req_left_q <= '0;
      end else begin
         vs_q <= vin_vs_i;
         frame_start_q <= vs_rise;
         case (state_q)
            IDLE: begin
               if (req_left_q == '0) begin
                  state_q <= DONE;
               end else if (push_o.room) begin
                  state_q <= ADDR;
                  ar_addr_q <= next_addr_q;
                  next_addr_q <= next_addr_q + BURST_BYTES;
                  if (req_left_q <= BURST_BYTES) begin
                     req_left_q <= '0;
                  end else begin
                     req_left_q <= req_left_q - BURST_BYTES;
                  end
               end
            end
            ADDR: begin
               if (arready_i) begin
                  state_q <= DATA;
               end
            end
            DATA: begin
               if (burst_end) begin
                  state_q <= IDLE;
                  drop_q <= 1'b0;
               end
            end
            default: ;
         endcase
         // An open burst runs to its end and its beats are dropped.
         if (vs_rise) begin
            next_addr_q <= `OVL_BASE;
            req_left_q <= FRAME_BYTES;
            if (state_q == ADDR || (state_q == DATA && !burst_end)) begin
               drop_q <= 1'b1;
            end else begin
               state_q <= IDLE;
            end
         end
      end
   end

   assign araddr_o = ar_addr_q;
   assign arlen_o = 4'(`OVL_BURST_LEN - 1);
   assign arvalid_o = (state_q == ADDR);
   assign rready_o = (state_q == DATA);

   assign push_o.beat_valid = (state_q == DATA) && rvalid_i && !drop_q;
   assign push_o.beat = rdata_i;
   assign push_o.frame_start = frame_start_q;

endmodule

// ==== hw/overlay_top.sv ====
`timescale 1ns/100ps

module overlay_top
   import video_pkg::*;
(
   input logic vin_clk_i,
   input logic rst_ni,
   input logic [2:0] mode_i,

   input logic vin_vs_i,
   input logic vin_de_i,
   input logic [PIX_W-1:0] data_i,
   output logic [PIX_W-1:0] data_o,

   output logic [31:0] araddr_o,
   output logic [3:0] arlen_o,
   output logic arvalid_o,
   input logic arready_i,
   input logic [63:0] rdata_i,
   input logic rvalid_i,
   output logic rready_o,
   input logic rlast_i
);

   logic [2:0] mode;
   logic en;
   logic [7:0] mask;

   beat_push_if push_if ();

   overlay_ctrl i_ctrl (
      .vin_clk_i (vin_clk_i),
      .rst_ni (rst_ni),
      .vin_vs_i (vin_vs_i),
      .push_o (push_if.producer),
      .araddr_o (araddr_o),
      .arlen_o (arlen_o),
      .arvalid_o (arvalid_o),
      .arready_i (arready_i),
      .rdata_i (rdata_i),
      .rvalid_i (rvalid_i),
      .rready_o (rready_o),
      .rlast_i (rlast_i)
   );

   mask_timer i_timer (
      .vin_clk_i (vin_clk_i),
      .rst_ni (rst_ni),
      .mode_i (mode_i),
      .mode_o (mode),
      .en_o (en)
   );

   // One mask byte per active pixel.
   mask_fifo i_fifo (
      .vin_clk_i (vin_clk_i),
      .rst_ni (rst_ni),
      .push_i (push_if.consumer),
      .pop_i (vin_de_i),
      .mask_o (mask)
   );

   pixel_blend i_blend (
      .vin_clk_i (vin_clk_i),
      .rst_ni (rst_ni),
      .de_i (vin_de_i),
      .data_i (data_i),
      .mask_i (mask),
      .mode_i (mode),
      .en_i (en),
      .data_o (data_o)
   );

endmodule

// ==== hw/pixel_blend.sv ====
`timescale 1ns/100ps

module pixel_blend
   import video_pkg::*;
(
   input logic vin_clk_i,
   input logic rst_ni,
   input logic de_i,
   input logic [PIX_W-1:0] data_i,
   input logic [7:0] mask_i,
   input logic [2:0] mode_i,
   input logic en_i,
   output logic [PIX_W-1:0] data_o
);

   logic de_q;
   logic en_q;
   logic [2:0] mode_q;
   logic [PIX_W-1:0] px_q;
   logic [PIX_W-1:0] folded;
   logic do_fold;

   // Stage 1 lines up with the popped mask byte.
   always_ff @(posedge vin_clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         de_q <= 1'b0;
         en_q <= 1'b0;
         mode_q <= '0;
      end else begin
         de_q <= de_i;
         en_q <= en_i;
         mode_q <= mode_i;
      end
   end

   always_ff @(posedge vin_clk_i) begin
      px_q <= data_i;
   end

   assign do_fold = de_q && en_q && mask_i[mode_q];

   always_comb begin
      for (int c = 0; c < NUM_CH; c++) begin
         folded[c*CH_W +: CH_W] = fold_channel(px_q[c*CH_W +: CH_W]);
      end
   end

   always_ff @(posedge vin_clk_i) begin
      data_o <= do_fold ? folded : px_q;
   end

endmodule

// ==== tb.f ====
+incdir+common
common/mem_pkg.sv
common/video_pkg.sv
common/beat_push_if.sv
hw/overlay_ctrl.sv
hw/mask_timer.sv
hw/mask_fifo.sv
hw/pixel_blend.sv
hw/overlay_top.sv
test/clk_gen.sv
test/overlay_tb.sv

// ==== test/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
   parameter real PERIOD = 4.0,
   parameter int RST_CYCLES = 3
) (
   output logic clk_o,
   output logic rst_no
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2.0) clk_o = ~clk_o;
   end

   // Reset is released on a falling edge.
   initial begin
      rst_no = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_no = 1'b1;
   end

endmodule

// ==== test/overlay_tb.sv ====
`timescale 1ns/100ps

`include "overlay_consts.svh"

module overlay_tb
   import mem_pkg::*, video_pkg::*;
();

   localparam int H = `OVL_H_WIDTH;
   localparam int V = `OVL_V_HEIGHT;
   localparam int RESET_TIMEOUT = 20;
   localparam int FILL_TIMEOUT = 400;
   localparam int DRAIN_TIMEOUT = 20;

   logic vin_clk;
   logic rst_n;
   logic [2:0] mode;
   logic vin_vs;
   logic vin_de;
   logic [PIX_W-1:0] data_in;
   logic [PIX_W-1:0] data_out;
   logic [31:0] araddr;
   logic [3:0] arlen;
   logic arvalid;
   logic arready;
   logic [BEAT_W-1:0] rdata;
   logic rvalid;
   logic rready;
   logic rlast;

   logic [PIX_W-1:0] exp_q[$];
   int edge_cnt = 0;
   int change_edge = 0;
   int beats_total = 0;
   int frame_cnt = 0;
   bit stall_en;

   clk_gen i_clk_gen (
      .clk_o (vin_clk),
      .rst_no (rst_n)
   );

   overlay_top dut0 (
      .vin_clk_i (vin_clk),
      .rst_ni (rst_n),
      .mode_i (mode),
      .vin_vs_i (vin_vs),
      .vin_de_i (vin_de),
      .data_i (data_in),
      .data_o (data_out),
      .araddr_o (araddr),
      .arlen_o (arlen),
      .arvalid_o (arvalid),
      .arready_i (arready),
      .rdata_i (rdata),
      .rvalid_i (rvalid),
      .rready_o (rready),
      .rlast_i (rlast)
   );

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      if (act_val !== exp_val) begin
         $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
         $display("Test FAILED");
         $fatal(1, "stopping at first error");
      end
   endtask

   // Mask memory holds a hash of the full byte address.
   function automatic logic [7:0] mask_byte(input logic [31:0] addr);
      logic [31:0] h;
      h = addr * 32'h9E37_79B1;
      return h[31:24] ^ h[15:8];
   endfunction

   function automatic logic [BEAT_W-1:0] mem_beat(input logic [31:0] addr);
      mask_beat_u beat;
      for (int i = 0; i < BEAT_BYTES; i++) begin
         beat.bytes[i] = mask_byte(addr + 32'(i));
      end
      return beat.raw;
   endfunction

   function automatic logic [7:0] fold_value(input logic [7:0] ch);
      int v;
      v = ch;
      if (v >= 128) begin
         return 8'(v - 128);
      end else begin
         return 8'(127 - v);
      end
   endfunction

   function automatic logic [PIX_W-1:0] expected_pixel(input int idx,
                                                      input logic [PIX_W-1:0] pix,
                                                      input logic [2:0] sel,
                                                      input bit en);
      logic [7:0] mbyte;
      logic [PIX_W-1:0] res;
      mbyte = mask_byte(`OVL_BASE + 32'(idx));
      res = pix;
      if (en && mbyte[sel]) begin
         for (int c = 0; c < 3; c++) begin
            res[c*8 +: 8] = fold_value(pix[c*8 +: 8]);
         end
      end
      return res;
   endfunction

   // Active edges since reset release. The reset state counts as a mode change at edge 0.
   always @(posedge vin_clk) begin
      if (rst_n) begin
         edge_cnt <= edge_cnt + 1;
      end
   end

   // AXI read slave with random stalls on arready and rvalid.
   initial begin : axi_memory
      logic [31:0] rd_addr;
      logic [31:0] exp_addr;
      int beats_left;
      logic vs_prev;
      bit ar_hs;
      bit r_hs;
      bit stall;
      arready = 1'b0;
      rvalid = 1'b0;
      rdata = '0;
      rlast = 1'b0;
      rd_addr = '0;
      exp_addr = `OVL_BASE;
      beats_left = 0;
      vs_prev = 1'b0;
      forever begin
         @(posedge vin_clk);
         ar_hs = arvalid && arready;
         r_hs = rvalid && rready;
         stall = stall_en;
         if (vin_vs && !vs_prev) begin
            exp_addr = `OVL_BASE;
         end
         vs_prev = vin_vs;
         if (ar_hs) begin
            check_value("araddr_o", exp_addr, araddr);
            check_value("arlen_o", `OVL_BURST_LEN - 1, arlen);
            rd_addr = araddr;
            beats_left = int'(arlen) + 1;
            exp_addr = exp_addr + `OVL_BURST_LEN * BEAT_BYTES;
         end
         if (r_hs) begin
            rd_addr = rd_addr + BEAT_BYTES;
            beats_left--;
            beats_total++;
         end
         @(negedge vin_clk);
         if (beats_left > 0) begin
            arready = 1'b0;
            // A beat on offer stays until it is taken.
            if (!rvalid || r_hs) begin
               rvalid = stall ? (($urandom % 3) != 0) : 1'b1;
            end
            rdata = mem_beat(rd_addr);
            rlast = (beats_left == 1);
         end else begin
            arready = stall ? (($urandom % 3) != 0) : 1'b1;
            rvalid = 1'b0;
            rlast = 1'b0;
         end
      end
   end

   // Output for the pixel sampled at edge k is read half a cycle after edge k+1.
   initial begin : compare_outputs
      logic de_d1;
      logic de_d2;
      logic [PIX_W-1:0] exp_pix;
      de_d1 = 1'b0;
      de_d2 = 1'b0;
      forever begin
         @(posedge vin_clk);
         de_d2 = de_d1;
         de_d1 = vin_de;
         @(negedge vin_clk);
         if (de_d2) begin
            if (exp_q.size() == 0) begin
               report_failure("output pixel arrived with no expected value queued");
            end else begin
               exp_pix = exp_q.pop_front();
               check_value("data_o", exp_pix, data_out);
            end
         end
      end
   end

   task automatic wait_reset();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1) begin
         if (cycles >= RESET_TIMEOUT) begin
            report_failure("timeout waiting for reset release");
         end else begin
            @(posedge vin_clk);
            cycles++;
         end
      end
      @(negedge vin_clk);
   endtask

   task automatic wait_fill(input int beats0);
      int cycles;
      cycles = 0;
      while (beats_total - beats0 < `OVL_FIFO_BEATS) begin
         if (cycles >= FILL_TIMEOUT) begin
            report_failure("timeout waiting for the mask buffer to fill");
         end else begin
            @(negedge vin_clk);
            cycles++;
         end
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0) begin
         if (cycles >= DRAIN_TIMEOUT) begin
            report_failure("timeout waiting for the last output pixels");
         end else begin
            @(negedge vin_clk);
            cycles++;
         end
      end
   endtask

   task automatic run_frame(input logic [2:0] new_mode, input bit stalls);
      int idx;
      int beats0;
      int folded;
      int k;
      bit en;
      logic [PIX_W-1:0] pix;
      logic [PIX_W-1:0] exp_pix;
      // The mode change is seen at the next edge.
      if (new_mode != mode) begin
         change_edge = edge_cnt + 1;
      end
      mode = new_mode;
      stall_en = stalls;
      beats0 = beats_total;
      vin_vs = 1'b1;
      repeat (2) @(negedge vin_clk);
      vin_vs = 1'b0;
      repeat (64) @(negedge vin_clk);
      wait_fill(beats0);
      idx = 0;
      folded = 0;
      for (int line = 0; line < V; line++) begin
         for (int x = 0; x < H; x++) begin
            k = edge_cnt + 1;
            en = (k > change_edge) && (k <= change_edge + int'(`OVL_MAX_CNT));
            pix = PIX_W'($urandom);
            exp_pix = expected_pixel(idx, pix, mode, en);
            exp_q.push_back(exp_pix);
            if (exp_pix != pix) begin
               folded++;
            end
            vin_de = 1'b1;
            data_in = pix;
            idx++;
            @(negedge vin_clk);
         end
         vin_de = 1'b0;
         data_in = '0;
         repeat (8) @(negedge vin_clk);
      end
      wait_drain();
      check_value("read beats per frame", (H * V) / BEAT_BYTES, beats_total - beats0);
      frame_cnt++;
      $display("Frame %0d, mode %0d: %0d of %0d pixels folded", frame_cnt, mode, folded,
               H * V);
   endtask

   initial begin
      void'($urandom(51));
      mode = 3'd0;
      vin_vs = 1'b0;
      vin_de = 1'b0;
      data_in = '0;
      stall_en = 1'b1;
      wait_reset();
      run_frame(3'd0, 1'b1);
      for (int m = 1; m < 8; m++) begin
         run_frame(3'(m), 1'b1);
      end
      // Same mode kept, so the enable runs out partway and then stays off.
      run_frame(3'd7, 1'b0);
      run_frame(3'd7, 1'b1);
      run_frame(3'd2, 1'b1);
      run_frame(3'd2, 1'b0);
      $display("Test OK");
      $finish;
   end

endmodule
